//--- verilog.f
rv_pkg.sv
ifu.sv
idu.sv
regfile.sv
exu.sv
lsu.sv
rv_core.sv
core_sva.sv
core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
	exit 0
fi
exit 1

//--- core_tb.sv
module core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	localparam word_t NOP = 32'h0000_0013;	// addi x0, x0, 0
	localparam int MAX_CYCLES = 6 * 48;

	logic clk;
	logic rst_n;
	word_t inst;
	word_t pc;
	logic commit;
	logic wb_en;
	reg_addr_t wb_addr;
	word_t wb_data;

	word_t prog [64];
	word_t sregs [32];	// shadow registers
	logic [7:0] smem [1024];	// shadow data memory in bytes
	logic [31:0] lfsr_st = 32'h799c_7e5b;
	int pos;
	int errors = 0;
	int checks = 0;

	rv_core dut_i (
		.clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .commit(commit),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	assign inst = prog[pc[7:2]];	// instruction port answers in the same cycle

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(MAX_CYCLES * 40 + 2000);
		$display("watchdog expired, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_st[0];
		lfsr_st = lfsr_st >> 1;
		if (b) lfsr_st = lfsr_st ^ 32'hA300_0000;
		return b;
	endfunction

	function automatic word_t rand_bits(int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
		return r;
	endfunction

	task automatic check_word(string what, word_t exp, word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_reg(string what, reg_addr_t exp, reg_addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s expected x%0d got x%0d", $time, what, exp, act);
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s expected %b got %b", $time, what, exp, act);
		end
	endtask

	// standard RV32I encodings
	function automatic word_t enc_i(logic [6:0] op, funct3_t f3, reg_addr_t rd,
			reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_r(funct7_t f7, funct3_t f3, reg_addr_t rd,
			reg_addr_t rs1, reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_s(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
			logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t enc_j(reg_addr_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic new_prog();
		for (int i = 0; i < 64; i++) prog[i] = NOP;
		pos = 1;	// word 0 is passed over while commit is still low
	endtask

	task automatic emit(word_t w);
		prog[pos] = w;
		pos++;
	endtask

	task automatic load_const(reg_addr_t rd, word_t v);
		word_t up;
		up = v + 32'h800;
		emit({up[31:12], rd, 7'b0110111});
		emit(enc_i(7'b0010011, 3'b000, rd, rd, v[11:0]));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2 rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		for (int i = 0; i < 32; i++) sregs[i] = '0;
	endtask

	// reference model of one retiring instruction that updates shadow state
	task automatic predict(input word_t p, input word_t in, output logic we,
			output word_t v, output word_t nxt);
		logic [2:0] f3;
		logic [6:0] f7;
		word_t a, b, ii, si, bi, ji, ad;
		reg_addr_t rd;
		f3 = in[14:12];
		f7 = in[31:25];
		rd = in[11:7];
		a = sregs[in[19:15]];
		b = sregs[in[24:20]];
		ii = {{20{in[31]}}, in[31:20]};
		si = {{20{in[31]}}, in[31:25], in[11:7]};
		bi = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
		ji = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
		we = 1'b0;
		v = '0;
		nxt = p + 4;
		case (in[6:0])
			7'b0110111: begin
				we = 1;
				v = {in[31:12], 12'b0};
			end
			7'b0010111: begin
				we = 1;
				v = p + {in[31:12], 12'b0};
			end
			7'b1101111: begin
				we = 1;
				v = p + 4;
				nxt = p + ji;
			end
			7'b1100111: begin
				if (f3 == 0) begin
					we = 1;
					v = p + 4;
					nxt = (a + ii) & ~32'd1;
				end
			end
			7'b1100011: begin
				if ((f3 == 0 && a == b) || (f3 == 1 && a != b) ||
						(f3 == 5 && $signed(a) >= $signed(b))) nxt = p + bi;
			end
			7'b0000011: begin
				ad = a + ii;
				if (f3 == 2) begin
					we = 1;
					v = {smem[ad[9:0] + 3], smem[ad[9:0] + 2],
						smem[ad[9:0] + 1], smem[ad[9:0]]};
				end else if (f3 == 4) begin
					we = 1;
					v = {24'b0, smem[ad[9:0]]};
				end
			end
			7'b0100011: begin
				ad = a + si;
				if (f3 <= 2) smem[ad[9:0]] = b[7:0];
				if (f3 >= 1 && f3 <= 2) smem[ad[9:0] + 1] = b[15:8];
				if (f3 == 2) begin
					smem[ad[9:0] + 2] = b[23:16];
					smem[ad[9:0] + 3] = b[31:24];
				end
			end
			7'b0010011: begin
				we = 1;
				case (f3)
					0: v = a + ii;
					3: v = (a < ii) ? 1 : 0;
					4: v = a ^ ii;
					7: v = a & ii;
					1: begin
						if (f7 == 0) v = a << ii[4:0];
						else we = 0;
					end
					5: begin
						if (f7 == 7'h20) v = $signed(a) >>> ii[4:0];
						else we = 0;
					end
					default: we = 0;
				endcase
			end
			7'b0110011: begin
				we = (f7 == 0);
				case (f3)
					0: v = a + b;
					1: v = a << b[4:0];
					3: v = (a < b) ? 1 : 0;
					6: v = a | b;
					7: v = a & b;
					default: we = 0;
				endcase
			end
			default: we = 0;	// anything else is a no-op
		endcase
		if (rd == 0) we = 0;
		if (we) sregs[rd] = v;
	endtask

	task automatic run_prog(string name);
		int err0;
		logic we;
		word_t v, nxt, exp_pc;
		err0 = errors;
		apply_reset();
		@(negedge clk);
		check_bit("commit after reset", 1'b0, commit);
		check_word("pc after reset", RESET_PC, pc);
		exp_pc = 32'd4;
		repeat (pos + 1) begin
			@(negedge clk);
			if (commit !== 1'b1) begin
				errors++;
				$display("no commit seen at time %0t ns for pc %h", $time, exp_pc);
			end
			check_word("pc", exp_pc, pc);
			predict(exp_pc, prog[exp_pc[7:2]], we, v, nxt);
			check_bit("wb_en", we, wb_en);
			if (we) begin
				check_reg("wb_addr", prog[exp_pc[7:2]][11:7], wb_addr);
				check_word("wb_data", v, wb_data);
			end
			exp_pc = nxt;
		end
		if (errors == err0) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - err0);
	endtask

	task automatic test_reset();
		new_prog();
		pos = 8;
		run_prog("reset");
	endtask

	task automatic test_alu();
		new_prog();
		load_const(1, rand_bits(32));
		load_const(2, rand_bits(32));
		load_const(3, rand_bits(32) | 32'h8000_0000);	// negative for srai
		emit(enc_i(7'b0010011, f3_add, 4, 1, rand_bits(12)));
		emit(enc_i(7'b0010011, f3_sltu, 5, 1, rand_bits(12)));
		emit(enc_i(7'b0010011, f3_xor, 6, 2, rand_bits(12)));
		emit(enc_i(7'b0010011, f3_and, 7, 2, rand_bits(12)));
		emit(enc_i(7'b0010011, f3_sll, 8, 1, {7'b0, 5'(rand_bits(5))}));
		// nonzero shift so the sign fill shows
		emit(enc_i(7'b0010011, f3_sr, 9, 3, {7'b0100000, 5'(rand_bits(5)) | 5'd1}));
		emit(enc_r(f7_base, f3_add, 10, 1, 2));
		emit(enc_r(f7_base, f3_sll, 11, 2, 1));
		emit(enc_r(f7_base, f3_sltu, 12, 1, 2));
		emit(enc_r(f7_base, f3_or, 13, 1, 3));
		emit(enc_r(f7_base, f3_and, 14, 2, 3));
		run_prog("alu");
	endtask

	task automatic test_upper();
		new_prog();
		emit({20'(rand_bits(20)), 5'd6, 7'b0110111});
		emit({20'(rand_bits(20)), 5'd7, 7'b0010111});
		emit(enc_i(7'b0010011, f3_add, 0, 7, 12'd5));	// write to x0 is dropped
		emit(enc_r(f7_base, f3_add, 8, 0, 0));
		emit(enc_r(f7_base, f3_or, 9, 0, 6));
		run_prog("upper");
	endtask

	task automatic test_mem();
		new_prog();
		load_const(1, 32'h0000_0100);
		load_const(2, rand_bits(32));
		load_const(3, rand_bits(32));
		emit(enc_s(f3_sw, 1, 2, 12'd0));
		emit(enc_s(f3_sw, 1, 3, 12'd4));
		emit(enc_s(f3_sh, 1, 3, 12'd2));
		emit(enc_s(f3_sh, 1, 2, 12'd4));
		emit(enc_s(f3_sb, 1, 2, 12'd5));
		emit(enc_i(7'b0000011, f3_lw, 4, 1, 12'd0));
		emit(enc_i(7'b0000011, f3_lw, 5, 1, 12'd4));
		emit(enc_i(7'b0000011, f3_lbu, 6, 1, 12'd3));
		emit(enc_i(7'b0000011, f3_lbu, 7, 1, 12'd5));
		emit(enc_i(7'b0000011, f3_lbu, 8, 1, 12'd7));
		run_prog("mem");
	endtask

	task automatic test_flow();
		new_prog();
		load_const(1, 32'd5);
		load_const(2, 32'd5);
		load_const(3, 32'hFFFF_FFFD);	// -3
		emit(enc_j(10, 21'd8));
		emit(enc_i(7'b0010011, f3_add, 11, 0, 12'd1));	// skipped
		emit(enc_i(7'b0010011, f3_add, 13, 0, 12'((pos + 3) * 4 + 1)));
		emit(enc_i(7'b1100111, f3_jalr, 12, 13, 12'd0));
		emit(enc_i(7'b0010011, f3_add, 11, 0, 12'd2));	// skipped
		emit(enc_b(f3_beq, 1, 2, 13'd8));
		emit(NOP);
		emit(enc_b(f3_bne, 1, 2, 13'd8));
		emit(enc_b(f3_bne, 1, 3, 13'd8));
		emit(NOP);
		emit(enc_b(f3_bge, 3, 1, 13'd8));
		emit(enc_b(f3_bge, 1, 3, 13'd8));
		emit(NOP);
		emit(enc_b(f3_beq, 1, 3, 13'd8));
		run_prog("flow");
	endtask

	task automatic test_unsupported();
		new_prog();
		load_const(1, rand_bits(32));
		emit(32'h0000_108F);	// misc-mem opcode with rd x1
		emit(enc_r(f7_alt, f3_add, 1, 1, 1));	// sub is outside the subset
		emit(enc_i(7'b0000011, 3'b001, 2, 0, 12'd0));	// lh
		emit(enc_r(f7_base, f3_or, 3, 1, 0));
		run_prog("unsupported");
	endtask

	initial begin
		rst_n = 1'b0;
		for (int i = 0; i < 64; i++) prog[i] = NOP;
		test_reset();
		test_alu();
		test_upper();
		test_mem();
		test_flow();
		test_unsupported();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- core_sva.sv
module core_sva (
	input logic clk,
	input logic rst_n,
	input rv_pkg::word_t pc,
	input logic commit,
	input logic wb_en,
	input rv_pkg::reg_addr_t wb_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	commit_low_in_reset: assert property (@(posedge clk) !rst_n |=> !commit)
		else $error("commit high right after a reset edge");

	wb_not_x0: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_addr != '0)
		else $error("register write aimed at x0");

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

	pc_moves: assert property (@(posedge clk) disable iff (!rst_n) commit |=> pc != $past(pc))
		else $error("pc held across a commit");

endmodule

bind rv_core core_sva sva_i (
	.clk(clk), .rst_n(rst_n), .pc(pc), .commit(commit), .wb_en(wb_en), .wb_addr(wb_addr)
);

//--- rv_core.sv
module rv_core #(
	parameter int DMEM_WORDS = 256,
	parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC
) (
	input logic clk,
	input logic rst_n,
	input rv_pkg::word_t inst,
	output rv_pkg::word_t pc,
	output logic commit,
	output logic wb_en,
	output rv_pkg::reg_addr_t wb_addr,
	output rv_pkg::word_t wb_data
);
	import rv_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	word_t imm;
	word_t src1;
	word_t src2;
	word_t val;
	word_t jump;
	word_t mem_addr;
	word_t rdata;
	wmask_t wmask;
	logic taken;
	logic mem_ren;
	logic mem_wen;
	logic dec_wb_en;
	logic store_en;

	// writes only for retiring instructions
	assign wb_en = dec_wb_en & commit;
	assign store_en = mem_wen & commit;
	assign wb_addr = rd;
	assign wb_data = val;

	ifu #(.RESET_PC(RESET_PC)) ifu_i (
		.clk(clk), .rst_n(rst_n), .taken(taken), .jump(jump), .pc(pc), .commit(commit)
	);

	idu idu_i (
		.inst(inst), .opcode(opcode), .funct3(funct3), .funct7(funct7),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .wb_en(dec_wb_en)
	);

	regfile regfile_i (
		.clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
		.wb_en(wb_en), .wdata(val), .src1(src1), .src2(src2)
	);

	exu exu_i (
		.opcode(opcode), .funct3(funct3), .funct7(funct7), .src1(src1), .src2(src2),
		.imm(imm), .pc(pc), .rdata(rdata), .val(val), .jump(jump), .taken(taken),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .wmask(wmask)
	);

	lsu #(.DMEM_WORDS(DMEM_WORDS)) lsu_i (
		.clk(clk), .mem_ren(mem_ren), .mem_wen(store_en), .mem_addr(mem_addr),
		.wmask(wmask), .wdata(src2), .rdata(rdata)
	);

endmodule

//--- lsu.sv
module lsu #(
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic mem_ren,
	input logic mem_wen,
	input rv_pkg::word_t mem_addr,
	input rv_pkg::wmask_t wmask,
	input rv_pkg::word_t wdata,
	output rv_pkg::word_t rdata
);
	import rv_pkg::*;

	localparam int AW = $clog2(DMEM_WORDS);	// depth a power of two

	word_t mem [DMEM_WORDS];
	logic [AW-1:0] idx;
	word_t wdata_al;

	assign idx = mem_addr[AW+1:2];	// wraps modulo depth

	// move the low byte or halfword onto the lanes the mask selects
	assign wdata_al = wdata << {mem_addr[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (mem_wen) begin
			for (int b = 0; b < 4; b++) begin
				if (wmask[b]) begin
					mem[idx][8*b +: 8] <= wdata_al[8*b +: 8];
				end
			end
		end
	end

	assign rdata = mem_ren ? mem[idx] : '0;

endmodule

//--- exu.sv
module exu (
	input rv_pkg::opcode_t opcode,
	input rv_pkg::funct3_t funct3,
	input rv_pkg::funct7_t funct7,
	input rv_pkg::word_t src1,
	input rv_pkg::word_t src2,
	input rv_pkg::word_t imm,
	input rv_pkg::word_t pc,
	input rv_pkg::word_t rdata,
	output rv_pkg::word_t val,
	output rv_pkg::word_t jump,
	output logic taken,
	output logic mem_ren,
	output logic mem_wen,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::wmask_t wmask
);
	import rv_pkg::*;

	logic [1:0] boff;

	assign mem_addr = src1 + imm;
	assign boff = mem_addr[1:0];	// byte offset in word

	always_comb begin
		val = '0;
		jump = '0;
		taken = 1'b0;
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		wmask = '0;
		case (opcode)
			op_lui: val = imm;
			op_auipc: val = pc + imm;
			op_jal: begin
				val = pc + 32'd4;	// link
				jump = pc + imm;
				taken = 1'b1;
			end
			op_jalr: begin
				if (funct3 == f3_jalr) begin
					val = pc + 32'd4;
					jump = (src1 + imm) & ~32'd1;
					taken = 1'b1;
				end
			end
			op_branch: begin
				jump = pc + imm;
				case (funct3)
					f3_beq: taken = (src1 == src2);
					f3_bne: taken = (src1 != src2);
					f3_bge: taken = ($signed(src1) >= $signed(src2));
					default: taken = 1'b0;
				endcase
			end
			op_load: begin
				case (funct3)
					f3_lw: begin
						mem_ren = 1'b1;
						val = rdata;
					end
					f3_lbu: begin
						mem_ren = 1'b1;
						val = {24'b0, rdata[{boff, 3'b000} +: 8]};
					end
					default: mem_ren = 1'b0;
				endcase
			end
			op_store: begin
				case (funct3)
					f3_sb: wmask = wmask_t'(4'b0001 << boff);
					f3_sh: wmask = wmask_t'(4'b0011 << boff);
					f3_sw: wmask = 4'b1111;
					default: wmask = '0;
				endcase
				mem_wen = |wmask;	// unknown width stores nothing
			end
			op_imm: begin
				case (funct3)
					f3_add: val = src1 + imm;
					f3_sltu: val = {31'b0, src1 < imm};
					f3_xor: val = src1 ^ imm;
					f3_and: val = src1 & imm;
					f3_sll: val = (funct7 == f7_base) ? src1 << imm[4:0] : '0;
					f3_sr: val = (funct7 == f7_alt) ? word_t'($signed(src1) >>> imm[4:0]) : '0;
					default: val = '0;
				endcase
			end
			op_reg: begin
				case ({funct7, funct3})
					{f7_base, f3_add}: val = src1 + src2;
					{f7_base, f3_sll}: val = src1 << src2[4:0];
					{f7_base, f3_sltu}: val = {31'b0, src1 < src2};
					{f7_base, f3_or}: val = src1 | src2;
					{f7_base, f3_and}: val = src1 & src2;
					default: val = '0;
				endcase
			end
			default: val = '0;	// unsupported opcode retires as a no-op
		endcase
	end

endmodule

//--- regfile.sv
module regfile (
	input logic clk,
	input logic rst_n,
	input rv_pkg::reg_addr_t rs1,
	input rv_pkg::reg_addr_t rs2,
	input rv_pkg::reg_addr_t rd,
	input logic wb_en,
	input rv_pkg::word_t wdata,
	output rv_pkg::word_t src1,
	output rv_pkg::word_t src2
);
	import rv_pkg::*;

	word_t regs [1:31];	// x0 has no storage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == '0) ? '0 : regs[rs1];
	assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- idu.sv
module idu (
	input rv_pkg::word_t inst,
	output rv_pkg::opcode_t opcode,
	output rv_pkg::funct3_t funct3,
	output rv_pkg::funct7_t funct7,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	output rv_pkg::reg_addr_t rd,
	output rv_pkg::word_t imm,
	output logic wb_en
);
	import rv_pkg::*;

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	logic writes_rd;

	assign opcode = opcode_t'(inst[6:0]);	// may hold an unlisted value
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd = inst[11:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			op_lui, op_auipc: imm = imm_u;
			op_jal: imm = imm_j;
			op_branch: imm = imm_b;
			op_store: imm = imm_s;
			op_jalr, op_load, op_imm: imm = imm_i;
			default: imm = '0;
		endcase
	end

	// only supported variants with a destination write back
	always_comb begin
		case (opcode)
			op_lui, op_auipc, op_jal: writes_rd = 1'b1;
			op_jalr: writes_rd = (funct3 == f3_jalr);
			op_load: writes_rd = (funct3 == f3_lw) || (funct3 == f3_lbu);
			op_imm: begin
				case (funct3)
					f3_add, f3_sltu, f3_xor, f3_and: writes_rd = 1'b1;
					f3_sll: writes_rd = (funct7 == f7_base);
					f3_sr: writes_rd = (funct7 == f7_alt);	// srai only
					default: writes_rd = 1'b0;
				endcase
			end
			op_reg: begin
				writes_rd = (funct7 == f7_base) &&
					(funct3 inside {f3_add, f3_sll, f3_sltu, f3_or, f3_and});
			end
			default: writes_rd = 1'b0;
		endcase
	end

	assign wb_en = writes_rd && (rd != '0);	// x0 never written

endmodule

//--- ifu.sv
module ifu #(
	parameter rv_pkg::word_t RESET_PC = rv_pkg::RESET_PC
) (
	input logic clk,
	input logic rst_n,
	input logic taken,
	input rv_pkg::word_t jump,
	output rv_pkg::word_t pc,
	output logic commit
);
	import rv_pkg::*;

	word_t pc_next;

	assign pc_next = taken ? jump : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// one instruction retires per cycle once out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			commit <= 1'b0;
		end else begin
			commit <= 1'b1;
		end
	end

endmodule

//--- rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [3:0] wmask_t;	// one bit per byte lane

	typedef enum logic [6:0] {
		op_lui = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal = 7'b1101111,
		op_jalr = 7'b1100111,
		op_branch = 7'b1100011,
		op_load = 7'b0000011,
		op_store = 7'b0100011,
		op_imm = 7'b0010011,
		op_reg = 7'b0110011
	} opcode_t;

	// branches
	localparam funct3_t f3_beq = 3'b000;
	localparam funct3_t f3_bne = 3'b001;
	localparam funct3_t f3_bge = 3'b101;

	// loads and stores
	localparam funct3_t f3_lw = 3'b010;
	localparam funct3_t f3_lbu = 3'b100;
	localparam funct3_t f3_sb = 3'b000;
	localparam funct3_t f3_sh = 3'b001;
	localparam funct3_t f3_sw = 3'b010;

	localparam funct3_t f3_jalr = 3'b000;

	// alu ops shared by op_imm and op_reg
	localparam funct3_t f3_add = 3'b000;
	localparam funct3_t f3_sll = 3'b001;
	localparam funct3_t f3_sltu = 3'b011;
	localparam funct3_t f3_xor = 3'b100;
	localparam funct3_t f3_sr = 3'b101;
	localparam funct3_t f3_or = 3'b110;
	localparam funct3_t f3_and = 3'b111;

	localparam funct7_t f7_base = 7'b0000000;
	localparam funct7_t f7_alt = 7'b0100000;	// srai

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage
